// ==== design/dm_config.svh ====
/*
 * debug module configuration
 * bus widths, register map, abstract command fields and memory wait
 */
`ifndef DM_CONFIG_SVH
`define DM_CONFIG_SVH

// bus and hart widths
`define DM_DATA_W 64
`define DM_ADDR_W 32
`define DM_XLEN 32

// register map, one word per register
`define DM_ADDR_DATA0 32'h0000_0004
`define DM_ADDR_DATA1 32'h0000_0005
`define DM_ADDR_CONTROL 32'h0000_0010
`define DM_ADDR_COMMAND 32'h0000_0017

// abstract command fields
`define DM_CMDTYPE_MSB 31
`define DM_CMDTYPE_LSB 24
`define DM_CMD_READ_BIT 16

// cycles given to the instruction memory before data0 is filled
`define DM_MEM_WAIT 8

`endif

// ==== design/dm_pkg.sv ====
/*
 * debug module types
 * bus FSM states, register selects and abstract command types
 */
package dm_pkg;

    // bus slave FSM states
    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } dm_bus_state_e;

    // decoded register select, SEL_NONE for unmapped addresses
    typedef enum logic [2:0]
    {
        SEL_DATA0   = 3'd0,
        SEL_DATA1   = 3'd1,
        SEL_CONTROL = 3'd2,
        SEL_COMMAND = 3'd3,
        SEL_NONE    = 3'd4
    } dm_reg_sel_e;

    // abstract command cmdtype field values
    typedef enum logic [7:0]
    {
        CMD_ACCESS_REG = 8'd0,
        CMD_QUICK      = 8'd1,
        CMD_ACCESS_MEM = 8'd2
    } dm_cmdtype_e;

endpackage

// ==== design/dm_bus_slave.sv ====
/*
 * debug module bus slave
 * cyc/stb/we FSM, address decode, single write strobe and ack generation
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module dm_bus_slave
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  logic [`DM_ADDR_W-1:0]  addr_i,
    input  logic [`DM_DATA_W-1:0]  rd_data_i,
    input  logic                   cmd_busy_i,
    output dm_pkg::dm_reg_sel_e    reg_sel_o,
    output logic                   wr_stb_o,
    output logic                   rd_stb_o,
    output logic [`DM_DATA_W-1:0]  data_o,
    output logic                   ack_o
);
    import dm_pkg::*;

    dm_bus_state_e state_q;
    // set once the write strobe of this transaction went out
    logic          wr_done_q;
    logic          req;

    // master request needs both strobes
    assign req = cyc_i && stb_i;

    // address decode, unmapped words select nothing
    always_comb
    begin
        case (addr_i)
            `DM_ADDR_DATA0:   reg_sel_o = SEL_DATA0;
            `DM_ADDR_DATA1:   reg_sel_o = SEL_DATA1;
            `DM_ADDR_CONTROL: reg_sel_o = SEL_CONTROL;
            `DM_ADDR_COMMAND: reg_sel_o = SEL_COMMAND;
            default:          reg_sel_o = SEL_NONE;
        endcase
    end

    // a held write acts only in its first cycle
    assign wr_stb_o = (state_q == WRITE) && req && !wr_done_q;
    assign rd_stb_o = (state_q == READ) && req;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q   <= IDLE;
            wr_done_q <= 1'b0;
            data_o    <= '0;
            ack_o     <= 1'b0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    data_o    <= '0;
                    ack_o     <= 1'b0;
                    wr_done_q <= 1'b0;
                    if (req)
                    begin
                        state_q <= we_i ? WRITE : READ;
                    end
                end
                READ:
                begin
                    if (rd_stb_o)
                    begin
                        // selected register is presented together with ack
                        data_o <= rd_data_i;
                        ack_o  <= 1'b1;
                    end
                    else
                    begin
                        data_o  <= '0;
                        ack_o   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                WRITE:
                begin
                    if (req)
                    begin
                        if (wr_stb_o)
                        begin
                            wr_done_q <= 1'b1;
                        end
                        // a memory read command holds ack back until data0 is filled
                        ack_o <= !cmd_busy_i;
                    end
                    else
                    begin
                        data_o    <= '0;
                        ack_o     <= 1'b0;
                        wr_done_q <= 1'b0;
                        state_q   <= IDLE;
                    end
                end
                default:
                begin
                    ack_o   <= 1'b0;
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/dm_register_file.sv ====
/*
 * debug module register file
 * data0 with bus and memory sources, data1, control and the read mux
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module dm_register_file
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  dm_pkg::dm_reg_sel_e    reg_sel_i,
    input  logic                   wr_stb_i,
    input  logic [`DM_DATA_W-1:0]  wr_data_i,
    input  logic                   mem_done_i,
    input  logic [`DM_XLEN-1:0]    mem_data_i,
    input  logic [`DM_DATA_W-1:0]  command_i,
    output logic [`DM_DATA_W-1:0]  data1_o,
    output logic [`DM_DATA_W-1:0]  rd_data_o
);
    import dm_pkg::*;

    logic [`DM_DATA_W-1:0] data0_q;
    logic [`DM_DATA_W-1:0] data1_q;
    logic [`DM_DATA_W-1:0] control_q;

    // data0 is written by the bus or filled by a memory read
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            data0_q <= '0;
        end
        else if (mem_done_i)
        begin
            // memory result is XLEN wide, upper half cleared
            data0_q <= {{(`DM_DATA_W - `DM_XLEN){1'b0}}, mem_data_i};
        end
        else if (wr_stb_i && (reg_sel_i == SEL_DATA0))
        begin
            // only the low XLEN bits of a bus write are kept
            data0_q <= {{(`DM_DATA_W - `DM_XLEN){1'b0}}, wr_data_i[`DM_XLEN-1:0]};
        end
    end

    // data1 and control take the full bus word
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            data1_q   <= '0;
            control_q <= '0;
        end
        else if (wr_stb_i)
        begin
            if (reg_sel_i == SEL_DATA1)
            begin
                data1_q <= wr_data_i;
            end
            if (reg_sel_i == SEL_CONTROL)
            begin
                control_q <= wr_data_i;
            end
        end
    end

    // data1 also carries the memory address for the command unit
    assign data1_o = data1_q;

    // read mux, the bus slave registers the result
    always_comb
    begin
        case (reg_sel_i)
            SEL_DATA0:   rd_data_o = data0_q;
            SEL_DATA1:   rd_data_o = data1_q;
            SEL_CONTROL: rd_data_o = control_q;
            SEL_COMMAND: rd_data_o = command_i;
            default:     rd_data_o = '0;
        endcase
    end

endmodule

// ==== design/dm_abstract_cmd.sv ====
/*
 * debug module abstract command unit
 * command register, access-memory read decode, pc drive and memory wait
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module dm_abstract_cmd
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  dm_pkg::dm_reg_sel_e    reg_sel_i,
    input  logic                   wr_stb_i,
    input  logic [`DM_DATA_W-1:0]  wr_data_i,
    input  logic [`DM_DATA_W-1:0]  data1_i,
    input  logic [`DM_XLEN-1:0]    instr_i,
    output logic [`DM_DATA_W-1:0]  command_o,
    output logic [`DM_XLEN-1:0]    pc_o,
    output logic                   cmd_busy_o,
    output logic                   mem_done_o,
    output logic [`DM_XLEN-1:0]    mem_data_o
);
    import dm_pkg::*;

    localparam int CNT_W = $clog2(`DM_MEM_WAIT + 1);

    dm_cmdtype_e      cmd_type;
    logic             cmd_wr;
    logic             mem_rd_cmd;
    logic             start;
    logic             wait_end;
    logic             busy_q;
    logic [CNT_W-1:0] count_q;

    // command decode straight off the bus write data
    assign cmd_wr     = wr_stb_i && (reg_sel_i == SEL_COMMAND);
    assign cmd_type   = dm_cmdtype_e'(wr_data_i[`DM_CMDTYPE_MSB:`DM_CMDTYPE_LSB]);
    assign mem_rd_cmd = cmd_wr && (cmd_type == CMD_ACCESS_MEM) && wr_data_i[`DM_CMD_READ_BIT];

    // a new memory read waits until the running one has filled data0
    assign start    = mem_rd_cmd && !busy_q && !mem_done_o;
    assign wait_end = busy_q && (count_q == CNT_W'(`DM_MEM_WAIT - 1));

    // busy already in the strobe cycle so the bus slave holds ack
    assign cmd_busy_o = mem_rd_cmd || busy_q || mem_done_o;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            command_o  <= '0;
            pc_o       <= '0;
            busy_q     <= 1'b0;
            count_q    <= '0;
            mem_done_o <= 1'b0;
        end
        else
        begin
            mem_done_o <= wait_end;
            // every command value is stored, only memory reads run
            if (cmd_wr)
            begin
                command_o <= wr_data_i;
            end
            if (start)
            begin
                pc_o    <= data1_i[`DM_XLEN-1:0];
                busy_q  <= 1'b1;
                count_q <= '0;
            end
            else if (wait_end)
            begin
                busy_q  <= 1'b0;
                count_q <= '0;
            end
            else if (busy_q)
            begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // memory word sampled on the last wait cycle
    always_ff @(posedge clk_i)
    begin
        if (wait_end)
        begin
            mem_data_o <= instr_i;
        end
    end

endmodule

// ==== design/dm_wishbone_slave.sv ====
/*
 * debug module register block top
 * bus slave, register file and abstract command unit
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module dm_wishbone_slave
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`DM_ADDR_W-1:0]  addr_i,
    input  logic                   we_i,
    input  logic [`DM_DATA_W-1:0]  data_i,
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic [`DM_XLEN-1:0]    instr_i,
    output logic [`DM_DATA_W-1:0]  data_o,
    output logic                   ack_o,
    output logic [`DM_XLEN-1:0]    pc_o
);
    import dm_pkg::*;

    dm_reg_sel_e           reg_sel;
    logic                  wr_stb;
    logic                  cmd_busy;
    logic                  mem_done;
    logic [`DM_XLEN-1:0]   mem_data;
    logic [`DM_DATA_W-1:0] command_q;
    logic [`DM_DATA_W-1:0] data1_q;
    logic [`DM_DATA_W-1:0] rd_data;

    // read strobe stays inside the bus slave
    dm_bus_slave i_dm_bus_slave (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cyc_i      (cyc_i),
        .stb_i      (stb_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .rd_data_i  (rd_data),
        .cmd_busy_i (cmd_busy),
        .reg_sel_o  (reg_sel),
        .wr_stb_o   (wr_stb),
        .rd_stb_o   (),
        .data_o     (data_o),
        .ack_o      (ack_o)
    );

    dm_register_file i_dm_register_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .reg_sel_i  (reg_sel),
        .wr_stb_i   (wr_stb),
        .wr_data_i  (data_i),
        .mem_done_i (mem_done),
        .mem_data_i (mem_data),
        .command_i  (command_q),
        .data1_o    (data1_q),
        .rd_data_o  (rd_data)
    );

    dm_abstract_cmd i_dm_abstract_cmd (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .reg_sel_i  (reg_sel),
        .wr_stb_i   (wr_stb),
        .wr_data_i  (data_i),
        .data1_i    (data1_q),
        .instr_i    (instr_i),
        .command_o  (command_q),
        .pc_o       (pc_o),
        .cmd_busy_o (cmd_busy),
        .mem_done_o (mem_done),
        .mem_data_o (mem_data)
    );

endmodule

// ==== test/tb_dm_wishbone_slave.sv ====
/*
 * testbench for the debug module register block
 * directed bus tests and memory read commands against an XOR memory model
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module tb_dm_wishbone_slave;
    import dm_pkg::*;

    localparam int          CLK_PERIOD    = 100;
    localparam logic [31:0] MEM_MASK      = 32'h5a5a_0f0f;
    // right shifting form of x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;
    localparam logic [31:0] ADDR_UNMAPPED = 32'h0000_0100;
    // longest wait for ack including a memory read
    localparam int          ACK_LIMIT     = `DM_MEM_WAIT + 10;
    localparam int          RANDOM_ROUNDS = 16;
    // bus transactions over all tests with nine per random round
    localparam int          NUM_TRANS     = 4 + 8 + 6 + 10 + RANDOM_ROUNDS * 9;

    logic                   clk_i;
    logic                   rst_i;
    logic [`DM_ADDR_W-1:0]  addr_i;
    logic                   we_i;
    logic [`DM_DATA_W-1:0]  data_i;
    logic                   cyc_i;
    logic                   stb_i;
    logic [`DM_XLEN-1:0]    instr_i;
    logic [`DM_DATA_W-1:0]  data_o;
    logic                   ack_o;
    logic [`DM_XLEN-1:0]    pc_o;

    logic [31:0] lfsr_q = 32'hec76e3d6;
    int          error_count = 0;
    int          check_count = 0;
    // expected register contents
    logic [63:0] exp_data0;
    logic [63:0] exp_data1;
    logic [63:0] exp_control;
    logic [63:0] exp_command;

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // instruction memory model whose word follows from the address alone
    assign instr_i = pc_o ^ MEM_MASK;

    dm_wishbone_slave i_dm_wishbone_slave (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .addr_i  (addr_i),
        .we_i    (we_i),
        .data_i  (data_i),
        .cyc_i   (cyc_i),
        .stb_i   (stb_i),
        .instr_i (instr_i),
        .data_o  (data_o),
        .ack_o   (ack_o),
        .pc_o    (pc_o)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[62:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("CHECK FAILED time %0t: %s = %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s finished, %0d errors", name, error_count - errs_before);
    endtask

    // one bus cycle where lat counts edges from the first sampled request to ack
    task automatic transfer(input logic write, input logic [31:0] addr,
                            input logic [63:0] wdata, output logic [63:0] rdata,
                            output int lat);
        int low_count;
        low_count = 0;
        rdata = '0;
        @(posedge clk_i);
        cyc_i  <= 1'b1;
        stb_i  <= 1'b1;
        we_i   <= write;
        addr_i <= addr;
        data_i <= wdata;
        // outputs are sampled mid cycle
        @(negedge clk_i);
        while (!ack_o && low_count < ACK_LIMIT)
        begin
            low_count++;
            @(negedge clk_i);
        end
        lat = low_count - 1;
        if (ack_o)
        begin
            rdata = data_o;
        end
        else
        begin
            $display("no ack from the DUT for the %s at address %h",
                     write ? "write" : "read", addr);
            error_count++;
        end
        @(posedge clk_i);
        cyc_i <= 1'b0;
        stb_i <= 1'b0;
        we_i  <= 1'b0;
        // ack falls one edge after the request goes away
        low_count = 0;
        @(negedge clk_i);
        while (ack_o && low_count < 4)
        begin
            low_count++;
            @(negedge clk_i);
        end
        if (ack_o)
        begin
            $display("ack stayed high after the request at address %h ended", addr);
            error_count++;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [63:0] data,
                             output int lat);
        logic [63:0] unused_rd;
        transfer(1'b1, addr, data, unused_rd, lat);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [63:0] data);
        int unused_lat;
        transfer(1'b0, addr, 64'h0, data, unused_lat);
    endtask

    task automatic check_regs();
        logic [63:0] rd;
        bus_read(`DM_ADDR_DATA0, rd);
        check_value("data0", rd, exp_data0);
        bus_read(`DM_ADDR_DATA1, rd);
        check_value("data1", rd, exp_data1);
        bus_read(`DM_ADDR_CONTROL, rd);
        check_value("control", rd, exp_control);
        bus_read(`DM_ADDR_COMMAND, rd);
        check_value("command", rd, exp_command);
    endtask

    // data1 write followed by an access-memory read command
    task automatic mem_read(input logic [63:0] addr_word, input logic [15:0] low_bits);
        logic [63:0] cmd;
        logic [63:0] rd;
        int          lat;
        cmd = '0;
        cmd[`DM_CMDTYPE_MSB:`DM_CMDTYPE_LSB] = CMD_ACCESS_MEM;
        cmd[`DM_CMD_READ_BIT] = 1'b1;
        cmd[15:0] = low_bits;
        bus_write(`DM_ADDR_DATA1, addr_word, lat);
        exp_data1 = addr_word;
        bus_write(`DM_ADDR_COMMAND, cmd, lat);
        exp_command = cmd;
        // memory word lands in the low half of data0
        exp_data0 = {32'h0, addr_word[31:0] ^ MEM_MASK};
        if (lat < `DM_MEM_WAIT || lat > `DM_MEM_WAIT + 4)
        begin
            $display("memory read command acknowledged after %0d cycles, allowed %0d to %0d",
                     lat, `DM_MEM_WAIT, `DM_MEM_WAIT + 4);
            error_count++;
        end
        check_value("pc_o", {32'h0, pc_o}, {32'h0, addr_word[31:0]});
        bus_read(`DM_ADDR_DATA0, rd);
        check_value("data0", rd, exp_data0);
        bus_read(`DM_ADDR_COMMAND, rd);
        check_value("command", rd, exp_command);
    endtask

    task automatic after_reset();
        int errs;
        errs = error_count;
        @(negedge clk_i);
        check_value("ack_o", {63'h0, ack_o}, 64'h0);
        check_value("data_o", data_o, 64'h0);
        check_value("pc_o", {32'h0, pc_o}, 64'h0);
        exp_data0   = '0;
        exp_data1   = '0;
        exp_control = '0;
        exp_command = '0;
        check_regs();
        report_test("reset", errs);
    endtask

    task automatic readback_all();
        int          errs;
        int          lat;
        logic [63:0] value;
        errs = error_count;
        value = random_bits(64);
        bus_write(`DM_ADDR_DATA1, value, lat);
        exp_data1 = value;
        value = random_bits(64);
        bus_write(`DM_ADDR_CONTROL, value, lat);
        exp_control = value;
        // access-register commands are only stored
        value = random_bits(64);
        value[`DM_CMDTYPE_MSB:`DM_CMDTYPE_LSB] = CMD_ACCESS_REG;
        bus_write(`DM_ADDR_COMMAND, value, lat);
        exp_command = value;
        value = random_bits(64);
        bus_write(`DM_ADDR_DATA0, value, lat);
        exp_data0 = {32'h0, value[31:0]};
        check_regs();
        report_test("readback", errs);
    endtask

    task automatic unmapped_access();
        int          errs;
        int          lat;
        logic [63:0] rd;
        errs = error_count;
        bus_read(ADDR_UNMAPPED, rd);
        check_value("unmapped read", rd, 64'h0);
        bus_write(ADDR_UNMAPPED, random_bits(64), lat);
        check_regs();
        report_test("unmapped", errs);
    endtask

    task automatic memory_read_cmd();
        int          errs;
        int          lat;
        logic [63:0] cmd;
        logic [63:0] first_addr;
        logic [63:0] next_addr;
        errs = error_count;
        first_addr = random_bits(64);
        mem_read(first_addr, 16'h0);
        // a new data1 would move pc_o and data0 if the next command ran
        next_addr = random_bits(64);
        bus_write(`DM_ADDR_DATA1, next_addr, lat);
        exp_data1 = next_addr;
        // a command with the read bit clear is stored only and acknowledged quickly
        cmd = exp_command;
        cmd[`DM_CMD_READ_BIT] = 1'b0;
        bus_write(`DM_ADDR_COMMAND, cmd, lat);
        exp_command = cmd;
        if (lat > 4)
        begin
            $display("command without read bit acknowledged after %0d cycles", lat);
            error_count++;
        end
        check_value("pc_o", {32'h0, pc_o}, {32'h0, first_addr[31:0]});
        check_regs();
        report_test("memory read", errs);
    endtask

    task automatic random_sequence();
        int          errs;
        int          lat;
        logic [63:0] addr_word;
        logic [63:0] low_bits;
        errs = error_count;
        for (int round = 0; round < RANDOM_ROUNDS; round++)
        begin
            addr_word = random_bits(64);
            exp_control = random_bits(64);
            bus_write(`DM_ADDR_CONTROL, exp_control, lat);
            low_bits = random_bits(16);
            mem_read(addr_word, low_bits[15:0]);
            check_regs();
        end
        report_test("random", errs);
    endtask

    initial
    begin
        rst_i  <= 1'b1;
        cyc_i  <= 1'b0;
        stb_i  <= 1'b0;
        we_i   <= 1'b0;
        addr_i <= '0;
        data_i <= '0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        after_reset();
        readback_all();
        unmapped_access();
        memory_read_cmd();
        random_sequence();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog giving every transaction the longest ack wait
    initial
    begin
        #(NUM_TRANS * ACK_LIMIT * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d ns",
                 NUM_TRANS * ACK_LIMIT * CLK_PERIOD);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== dm_wishbone_slave.f ====
+incdir+design
design/dm_pkg.sv
design/dm_bus_slave.sv
design/dm_register_file.sv
design/dm_abstract_cmd.sv
design/dm_wishbone_slave.sv
test/tb_dm_wishbone_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the debug module testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_dm_wishbone_slave \
    -f dm_wishbone_slave.f \
    -o sim_dm_wishbone_slave

# the testbench decides pass or fail, the log is searched below
./obj_dir/sim_dm_wishbone_slave > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
